//--- Makefile
# Verilator simulation of the CRC-32 offload engine

VERILATOR ?= verilator
TOP ?= tb_eth_crc_top
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^Testbench passed$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
	parameter int HALF_PERIOD_NS = 20,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic reset
);

	// Free running clock, 40 ns period by default
	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD_NS) clk = ~clk;
	end

	// Reset drops just after an edge, like all other stimulus
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		reset = 1'b0;
	end

endmodule

//--- dv/tb_eth_crc_top.sv
`timescale 1ns/1ps

module tb_eth_crc_top;

	localparam int WB_ADDR_W = 4;
	localparam int DRIVE_DELAY = 2;
	localparam int ACK_TIMEOUT = 20;
	localparam int IDLE_TIMEOUT = 50;
	localparam int RESET_TIMEOUT = 20;
	localparam int RANDOM_SEED = 24700;
	localparam int MAX_BYTES = 64;
	localparam int NUM_FRAMES = 8;

	// Each row holds the word count, the bytes in the last word and the expect flag
	localparam int FRAME_TABLE [NUM_FRAMES][3] = '{
		'{1, 1, 1},
		'{1, 4, 0},
		'{2, 2, 1},
		'{3, 3, 0},
		'{5, 1, 1},
		'{9, 4, 0},
		'{16, 3, 1},
		'{16, 4, 1}
	};

	logic clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [WB_ADDR_W-1:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;

	int cycle_count = 0;
	logic [7:0] frame_bytes [MAX_BYTES];

	clk_gen u_clk_gen (
		.clk(clk),
		.reset(reset)
	);

	eth_crc_top #(
		.WB_ADDR_W(WB_ADDR_W)
	) u_eth_crc_top (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack)
	);

	// Time base for the idle poll
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	//////////////////////////////////////////////////
	// Reporting and reference model

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			abort_run($sformatf("Mismatch at %0t ns: %s expected %08h, actual %08h",
				$time, name, expected, actual));
		end
	endtask

	// Bitwise reflected CRC-32, then bytes swapped into wire order
	function automatic logic [31:0] model_fcs(input logic [7:0] data [MAX_BYTES],
			input int count);
		logic [31:0] crc;
		crc = 32'hFFFF_FFFF;
		for (int n = 0; n < count; n++) begin
			crc = crc ^ {24'h0, data[n]};
			for (int k = 0; k < 8; k++) begin
				if (crc[0]) begin
					crc = (crc >> 1) ^ 32'hEDB8_8320;
				end else begin
					crc = crc >> 1;
				end
			end
		end
		crc = ~crc;
		return {crc[7:0], crc[15:8], crc[23:16], crc[31:24]};
	endfunction

	//////////////////////////////////////////////////
	// Wishbone master

	task automatic wb_write(input int addr, input logic [31:0] data);
		logic acked;
		@(posedge clk);
		#DRIVE_DELAY;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = WB_ADDR_W'(addr);
		wb_dat_w = data;
		acked = 1'b0;
		for (int i = 0; i < ACK_TIMEOUT && !acked; i++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			acked = wb_ack;
		end
		if (!acked) begin
			abort_run($sformatf("No ack for a write to address %0d", addr));
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_read(input int addr, output logic [31:0] data);
		logic acked;
		@(posedge clk);
		#DRIVE_DELAY;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = WB_ADDR_W'(addr);
		acked = 1'b0;
		for (int i = 0; i < ACK_TIMEOUT && !acked; i++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			acked = wb_ack;
		end
		if (!acked) begin
			abort_run($sformatf("No ack for a read from address %0d", addr));
		end
		// Read data is registered together with ack
		data = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Frame helpers

	task automatic wait_reset_release();
		for (int i = 0; i < RESET_TIMEOUT && reset !== 1'b0; i++) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		if (reset !== 1'b0) begin
			abort_run("Reset was never released");
		end
	endtask

	// Poll STATUS until busy clears
	task automatic wait_idle();
		logic [31:0] status;
		int start_cycle;
		start_cycle = cycle_count;
		wb_read(eth_crc_pkg::REG_STATUS, status);
		while (status[0] && (cycle_count - start_cycle) < IDLE_TIMEOUT) begin
			wb_read(eth_crc_pkg::REG_STATUS, status);
		end
		if (status[0]) begin
			abort_run("STATUS busy stayed high past the timeout");
		end
	endtask

	// Full words first, then the tail word with its own LEN
	task automatic send_frame(input logic [7:0] data [MAX_BYTES], input int count);
		int full_words;
		int last_len;
		logic [31:0] word;
		full_words = (count - 1) / 4;
		last_len = count - full_words * 4;
		wb_write(eth_crc_pkg::REG_LEN, 32'd4);
		for (int w = 0; w < full_words; w++) begin
			word = {data[4*w], data[4*w+1], data[4*w+2], data[4*w+3]};
			wb_write(eth_crc_pkg::REG_DATA, word);
		end
		// Unused low lanes carry junk that must be ignored
		word = $urandom();
		for (int b = 0; b < last_len; b++) begin
			word[31-8*b -: 8] = data[full_words*4 + b];
		end
		wb_write(eth_crc_pkg::REG_LEN, 32'(last_len));
		wb_write(eth_crc_pkg::REG_DATA, word);
	endtask

	task automatic fill_random(input int count);
		for (int i = 0; i < MAX_BYTES; i++) begin
			frame_bytes[i] = (i < count) ? 8'($urandom()) : 8'h00;
		end
	endtask

	//////////////////////////////////////////////////
	// Test steps

	task automatic check_reset_values();
		logic [31:0] rd;
		wb_read(eth_crc_pkg::REG_LEN, rd);
		check_value("LEN", 32'd4, rd);
		wb_read(eth_crc_pkg::REG_EXPECT, rd);
		check_value("EXPECT", 32'd0, rd);
		wb_read(eth_crc_pkg::REG_STATUS, rd);
		check_value("STATUS", 32'd0, rd);
		wb_read(eth_crc_pkg::REG_CTRL, rd);
		check_value("CTRL", 32'd0, rd);
		// Read back of the writable registers
		wb_write(eth_crc_pkg::REG_EXPECT, 32'hA5C3_0F96);
		wb_read(eth_crc_pkg::REG_EXPECT, rd);
		check_value("EXPECT", 32'hA5C3_0F96, rd);
		wb_write(eth_crc_pkg::REG_LEN, 32'd3);
		wb_read(eth_crc_pkg::REG_LEN, rd);
		check_value("LEN", 32'd3, rd);
		wb_write(eth_crc_pkg::REG_LEN, 32'd4);
		wb_write(eth_crc_pkg::REG_EXPECT, 32'd0);
	endtask

	// ASCII 123456789, the usual check value
	task automatic check_known_vector();
		logic [31:0] rd;
		wb_write(eth_crc_pkg::REG_CTRL, 32'd1);
		wb_write(eth_crc_pkg::REG_LEN, 32'd4);
		wb_write(eth_crc_pkg::REG_DATA, 32'h3132_3334);
		wb_write(eth_crc_pkg::REG_DATA, 32'h3536_3738);
		wb_write(eth_crc_pkg::REG_LEN, 32'd1);
		wb_write(eth_crc_pkg::REG_DATA, {8'h39, 24'($urandom())});
		wait_idle();
		wb_read(eth_crc_pkg::REG_RESULT, rd);
		check_value("RESULT", 32'h2639_F4CB, rd);
	endtask

	task automatic run_frame_table();
		logic [31:0] rd;
		logic [31:0] fcs;
		logic [31:0] expect_val;
		int count;
		logic expect_ok;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			count = (FRAME_TABLE[f][0] - 1) * 4 + FRAME_TABLE[f][1];
			expect_ok = (FRAME_TABLE[f][2] != 0);
			fill_random(count);
			fcs = model_fcs(frame_bytes, count);
			// Wrong expect differs in a single bit
			expect_val = expect_ok ? fcs : fcs ^ (32'h1 << ($urandom() % 32));
			wb_write(eth_crc_pkg::REG_CTRL, 32'd1);
			wb_write(eth_crc_pkg::REG_EXPECT, expect_val);
			send_frame(frame_bytes, count);
			wait_idle();
			wb_read(eth_crc_pkg::REG_RESULT, rd);
			check_value("RESULT", fcs, rd);
			wb_read(eth_crc_pkg::REG_STATUS, rd);
			check_value("STATUS", {30'b0, expect_ok, 1'b0}, rd);
		end
	endtask

	task automatic check_zero_len_and_restart();
		logic [31:0] fcs;
		logic [31:0] rd;
		// Abandoned frame then a fresh one
		wb_write(eth_crc_pkg::REG_CTRL, 32'd1);
		wb_write(eth_crc_pkg::REG_LEN, 32'd4);
		wb_write(eth_crc_pkg::REG_DATA, $urandom());
		wb_write(eth_crc_pkg::REG_DATA, $urandom());
		wb_write(eth_crc_pkg::REG_CTRL, 32'd1);
		fill_random(11);
		fcs = model_fcs(frame_bytes, 11);
		send_frame(frame_bytes, 11);
		wait_idle();
		wb_read(eth_crc_pkg::REG_RESULT, rd);
		check_value("RESULT", fcs, rd);
		// Zero length word is dropped by the engine
		wb_write(eth_crc_pkg::REG_LEN, 32'd0);
		wb_write(eth_crc_pkg::REG_DATA, $urandom());
		wait_idle();
		wb_read(eth_crc_pkg::REG_RESULT, rd);
		check_value("RESULT", fcs, rd);
		// Frame goes on as if the empty word never came
		for (int b = 11; b < 15; b++) begin
			frame_bytes[b] = 8'($urandom());
		end
		fcs = model_fcs(frame_bytes, 15);
		wb_write(eth_crc_pkg::REG_LEN, 32'd4);
		wb_write(eth_crc_pkg::REG_DATA,
			{frame_bytes[11], frame_bytes[12], frame_bytes[13], frame_bytes[14]});
		wait_idle();
		wb_read(eth_crc_pkg::REG_RESULT, rd);
		check_value("RESULT", fcs, rd);
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		void'($urandom(RANDOM_SEED));
		wait_reset_release();
		check_reset_values();
		check_known_vector();
		run_frame_table();
		check_zero_len_and_restart();
		$display("Testbench passed");
		$finish;
	end

endmodule

//--- src/crc_ctl_if.sv
`timescale 1ns/1ps

interface crc_ctl_if;

	// Register block to sequencer
	logic start;
	logic word_valid;
	eth_crc_pkg::crc_word_t word;
	eth_crc_pkg::crc_len_t word_len;
	eth_crc_pkg::crc_value_t expect_fcs;

	// Sequencer back to register block
	eth_crc_pkg::crc_value_t result;
	logic busy;
	logic match;

	modport regs (
		output start, word_valid, word, word_len, expect_fcs,
		input result, busy, match
	);

	modport seq (
		input start, word_valid, word, word_len, expect_fcs,
		output result, busy, match
	);

endinterface

//--- src/crc_frame_seq.sv
`timescale 1ns/1ps

module crc_frame_seq (
	input logic clk,
	input logic reset,
	crc_ctl_if.seq ctl
);

	//////////////////////////////////////////////////
	// Engine hookup

	logic engine_ce;
	logic engine_reset;
	logic new_word;
	eth_crc_pkg::crc_value_t crc_out;

	// Start reseeds the engine and drops anything still in flight
	assign engine_reset = reset || ctl.start;
	assign engine_ce = ctl.word_valid || ctl.start;

	// Zero length words never reach crc_out
	assign new_word = ctl.word_valid && (ctl.word_len != '0);

	eth_crc32_x32 u_engine (
		.clk(clk),
		.reset(engine_reset),
		.ce(engine_ce),
		.din_len(ctl.word_len),
		.din(ctl.word),
		.crc_out(crc_out)
	);

	//////////////////////////////////////////////////
	// In flight tracking and capture

	// Two entries for the two engine stages
	logic [1:0] in_flight;
	eth_crc_pkg::crc_value_t result_q;
	logic result_valid;

	always_ff @(posedge clk) begin
		if (engine_reset) begin
			in_flight <= '0;
			result_q <= '0;
			result_valid <= 1'b0;
		end else begin
			in_flight <= {in_flight[0], new_word};
			// Tail set means crc_out holds this word's FCS
			if (in_flight[1]) begin
				result_q <= crc_out;
				result_valid <= 1'b1;
			end
		end
	end

	assign ctl.result = result_q;

	// High in the same cycle as the word pulse
	assign ctl.busy = new_word || (|in_flight);

	// Check mode compare, only once something was captured
	assign ctl.match = result_valid && !ctl.busy && (result_q == ctl.expect_fcs);

	busy_bounded: assert property (
		@(posedge clk) disable iff (reset)
		ctl.word_valid ##1 (!ctl.word_valid) [*3] |-> !ctl.busy
	);

endmodule

//--- src/crc_wb_regs.sv
`timescale 1ns/1ps

module crc_wb_regs #(
	parameter int WB_ADDR_W = 4
) (
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [WB_ADDR_W-1:0] wb_adr,
	input eth_crc_pkg::crc_word_t wb_dat_w,
	output eth_crc_pkg::crc_word_t wb_dat_r,
	output logic wb_ack,
	crc_ctl_if.regs ctl
);

	//////////////////////////////////////////////////
	// Bus request and address decode

	logic request;
	logic wr;
	logic sel_ctrl;
	logic sel_data;
	logic sel_len;
	logic sel_result;
	logic sel_status;
	logic sel_expect;

	// New cycle only while ack is low, so ack is one clock wide
	assign request = wb_cyc && wb_stb && !wb_ack;
	assign wr = request && wb_we;

	assign sel_ctrl = wb_adr == WB_ADDR_W'(eth_crc_pkg::REG_CTRL);
	assign sel_data = wb_adr == WB_ADDR_W'(eth_crc_pkg::REG_DATA);
	assign sel_len = wb_adr == WB_ADDR_W'(eth_crc_pkg::REG_LEN);
	assign sel_result = wb_adr == WB_ADDR_W'(eth_crc_pkg::REG_RESULT);
	assign sel_status = wb_adr == WB_ADDR_W'(eth_crc_pkg::REG_STATUS);
	assign sel_expect = wb_adr == WB_ADDR_W'(eth_crc_pkg::REG_EXPECT);

	//////////////////////////////////////////////////
	// Control registers and command pulses

	eth_crc_pkg::crc_len_t len_q;
	eth_crc_pkg::crc_value_t expect_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
			ctl.start <= 1'b0;
			ctl.word_valid <= 1'b0;
			// Full words by default
			len_q <= 3'd4;
			expect_q <= '0;
		end else begin
			wb_ack <= request;
			// Pulses last one cycle since request drops with ack
			ctl.start <= wr && sel_ctrl && wb_dat_w[0];
			ctl.word_valid <= wr && sel_data;
			if (wr && sel_len) begin
				len_q <= wb_dat_w[2:0];
			end
			if (wr && sel_expect) begin
				expect_q <= wb_dat_w;
			end
		end
	end

	// Data word rides alongside the word_valid pulse
	always_ff @(posedge clk) begin
		if (wr && sel_data) begin
			ctl.word <= wb_dat_w;
		end
	end

	assign ctl.word_len = len_q;
	assign ctl.expect_fcs = expect_q;

	//////////////////////////////////////////////////
	// Read back

	eth_crc_pkg::crc_word_t read_data;

	// CTRL, DATA and holes read as zero
	always_comb begin
		read_data = '0;
		if (sel_len) begin
			read_data = eth_crc_pkg::crc_word_t'(len_q);
		end
		if (sel_result) begin
			read_data = ctl.result;
		end
		if (sel_status) begin
			read_data = {30'b0, ctl.match, ctl.busy};
		end
		if (sel_expect) begin
			read_data = expect_q;
		end
	end

	// Read data lands together with ack
	always_ff @(posedge clk) begin
		if (request) begin
			wb_dat_r <= read_data;
		end
	end

	ack_single_cycle: assert property (
		@(posedge clk) disable iff (reset)
		wb_ack |=> !wb_ack
	);

endmodule

//--- src/eth_crc32_x32.sv
`timescale 1ns/1ps

module eth_crc32_x32 (
	input logic clk,
	input logic reset,
	input logic ce,
	input eth_crc_pkg::crc_len_t din_len,
	input eth_crc_pkg::crc_word_t din,
	output eth_crc_pkg::crc_value_t crc_out
);

	// One byte through the shift register, LSB first as on the wire
	function automatic eth_crc_pkg::crc_value_t fold_byte(
		input eth_crc_pkg::crc_value_t state,
		input logic [7:0] data
	);
		eth_crc_pkg::crc_value_t next;
		logic fb;
		next = state;
		for (int i = 0; i < 8; i++) begin
			fb = data[i] ^ next[31];
			next = {next[30:0], 1'b0} ^ (fb ? eth_crc_pkg::CRC_POLY : '0);
		end
		return next;
	endfunction

	//////////////////////////////////////////////////
	// Stage 1 byte folding

	eth_crc_pkg::crc_value_t crc;
	eth_crc_pkg::crc_value_t byte_state [4];
	eth_crc_pkg::crc_value_t next_crc;
	eth_crc_pkg::crc_value_t saved_state [4];
	eth_crc_pkg::crc_len_t len_ff;
	logic stage_valid;
	logic take;

	// A zero length word is a no-op
	assign take = ce && (din_len != '0);

	// Chain of byte states, top byte of din first
	always_comb begin
		byte_state[0] = fold_byte(crc, din[31:24]);
		for (int n = 1; n < 4; n++) begin
			byte_state[n] = fold_byte(byte_state[n-1], din[(3-n)*8 +: 8]);
		end
	end

	// Running state follows the byte count of this word
	always_comb begin
		case (din_len)
			3'd1: next_crc = byte_state[0];
			3'd2: next_crc = byte_state[1];
			3'd3: next_crc = byte_state[2];
			default: next_crc = byte_state[3];
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			crc <= eth_crc_pkg::CRC_INIT;
			stage_valid <= 1'b0;
		end else begin
			stage_valid <= take;
			if (take) begin
				crc <= next_crc;
			end
		end
	end

	// Intermediate states and length for stage 2
	always_ff @(posedge clk) begin
		if (take) begin
			saved_state <= byte_state;
			len_ff <= din_len;
		end
	end

	//////////////////////////////////////////////////
	// Stage 2 select, invert and renumber

	eth_crc_pkg::crc_value_t fcrc;
	eth_crc_pkg::crc_value_t fcs_next;

	always_comb begin
		case (len_ff)
			3'd1: fcrc = ~saved_state[0];
			3'd2: fcrc = ~saved_state[1];
			3'd3: fcrc = ~saved_state[2];
			default: fcrc = ~saved_state[3];
		endcase
	end

	// Bits reversed inside each byte, byte lanes kept
	always_comb begin
		for (int b = 0; b < 4; b++) begin
			for (int i = 0; i < 8; i++) begin
				fcs_next[b*8 + i] = fcrc[b*8 + 7 - i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (stage_valid) begin
			crc_out <= fcs_next;
		end
	end

	// Partial words only close a frame
	logic partial;
	assign partial = ce && (din_len != '0) && (din_len < 3'd4);

	partial_not_repeated: assert property (
		@(posedge clk) disable iff (reset)
		partial |=> !partial
	);

endmodule

//--- src/eth_crc_pkg.sv
package eth_crc_pkg;

	//////////////////////////////////////////////////
	// Data types

	// One bus word, first byte on the wire in bits 31:24
	typedef logic [31:0] crc_word_t;

	// Valid bytes in a word
	// 0 means no data, 4 to 7 all mean a full word
	typedef logic [2:0] crc_len_t;

	// Running CRC state or finished FCS
	typedef logic [31:0] crc_value_t;

	//////////////////////////////////////////////////
	// CRC-32 constants

	// IEEE 802.3 generator in normal form
	// The x^32 term is implied
	localparam crc_value_t CRC_POLY = 32'h04C1_1DB7;

	// Seeding with ones inverts the first 32 bits of the frame
	localparam crc_value_t CRC_INIT = 32'hFFFF_FFFF;

	//////////////////////////////////////////////////
	// Register map in word addresses

	// Write 1 to bit 0 to restart the CRC
	localparam int REG_CTRL = 0;
	// Write only frame data
	localparam int REG_DATA = 1;
	// Byte count used for each DATA write
	localparam int REG_LEN = 2;
	// Last finished FCS
	localparam int REG_RESULT = 3;
	// Bit 0 busy, bit 1 match
	localparam int REG_STATUS = 4;
	// FCS to compare against in check mode
	localparam int REG_EXPECT = 5;

endpackage

//--- src/eth_crc_top.sv
`timescale 1ns/1ps

module eth_crc_top #(
	parameter int WB_ADDR_W = 4
) (
	input logic clk,
	input logic reset,

	// Wishbone classic slave
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [WB_ADDR_W-1:0] wb_adr,
	input eth_crc_pkg::crc_word_t wb_dat_w,
	output eth_crc_pkg::crc_word_t wb_dat_r,
	output logic wb_ack
);

	//////////////////////////////////////////////////
	// Register block to sequencer link

	crc_ctl_if ctl ();

	// Bus side
	crc_wb_regs #(
		.WB_ADDR_W(WB_ADDR_W)
	) u_crc_wb_regs (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.ctl(ctl.regs)
	);

	// CRC side with the engine inside
	crc_frame_seq u_crc_frame_seq (
		.clk(clk),
		.reset(reset),
		.ctl(ctl.seq)
	);

endmodule

//--- verilog.f
src/eth_crc_pkg.sv
src/crc_ctl_if.sv
src/eth_crc32_x32.sv
src/crc_wb_regs.sv
src/crc_frame_seq.sv
src/eth_crc_top.sv
dv/clk_gen.sv
dv/tb_eth_crc_top.sv
